// ==== source/cfg_net_pkg.sv ====
package cfg_net_pkg;

  // serial packet field widths
  localparam int id_width       = 4;  // node id field
  localparam int len_width      = 8;  // packet length field
  localparam int frame_len      = 8;  // payload bits between two framing bits
  localparam int frame_bit_size = 1;  // framing field, always sent as zero
  localparam int valid_bit_size = 2;  // start marker

  // start marker as it sits in the lowest shift bits
  // bit 0 leaves the serializer first and is the zero
  localparam logic [valid_bit_size-1:0] valid_pattern = 2'b10;

  // shortest run of ones that returns a node to its default
  // covers both frame fields around the length plus the length itself
  localparam int reset_len = 2 * frame_bit_size + len_width;

  // request kinds on the word port
  typedef enum logic {
    req_write       = 1'b0,  // load one node register
    req_chain_reset = 1'b1   // ones burst, all nodes back to default
  } req_kind_e;

endpackage

// ==== source/cfg_packet_serializer.sv ====
`timescale 1ns/1ps

module cfg_packet_serializer #(
  parameter int data_bits   = 12,
  parameter int req_credits = 4
) (
  input  logic                              clk,
  input  logic                              cfg_reset,
  input  logic                              req_valid,
  input  cfg_net_pkg::req_kind_e            req_kind,
  input  logic [cfg_net_pkg::id_width-1:0]  req_node,
  input  logic [data_bits-1:0]              req_data,
  output logic                              req_credit,  // one pulse per dequeued entry
  output logic                              cfg_bit      // serial line to the first node
);
  import cfg_net_pkg::*;

  // framed payload, msb is always a framing bit
  localparam int rx_len    = data_bits + data_bits / frame_len + frame_bit_size;
  localparam int pkt_len   = rx_len + 3 * frame_bit_size + id_width + len_width + valid_bit_size;
  localparam int tx_len    = reset_len + pkt_len;  // chain reset burst length
  localparam int ptr_w     = (req_credits > 1) ? $clog2(req_credits) : 1;
  localparam int cnt_w     = $clog2(req_credits + 1);
  localparam int len_cnt_w = $clog2(tx_len);
  localparam logic [len_width-1:0] len_field = len_width'(pkt_len);

  // request queue storage
  req_kind_e              q_kind [req_credits];
  logic [id_width-1:0]    q_node [req_credits];
  logic [data_bits-1:0]   q_data [req_credits];
  logic [ptr_w-1:0]       wr_ptr, rd_ptr;
  logic [cnt_w-1:0]       q_count;
  logic                   q_empty, q_full;

  logic                   tx_busy;     // a packet or reset burst is on the line
  logic [len_cnt_w-1:0]   bits_left;   // bits after the one now on cfg_bit
  logic [tx_len-1:0]      tx_sreg;     // outgoing bits, lsb is on the wire
  logic                   tx_last, tx_start;
  logic                   head_is_reset;
  logic [tx_len-1:0]      head_image;  // wire image of the queue head

  // spread payload bits over the frame layout
  function automatic logic [rx_len-1:0] frame_payload(input logic [data_bits-1:0] d);
    logic [rx_len-1:0] rx;
    rx = '0;  // framing positions stay zero
    for (int i = 0; i < rx_len - 1; i++) begin
      if ((i + 1) % (frame_len + frame_bit_size) != 0) begin
        rx[i] = d[i - i / (frame_len + frame_bit_size)];
      end
    end
    return rx;
  endfunction

  function automatic logic [ptr_w-1:0] ptr_inc(input logic [ptr_w-1:0] p);
    return (p == ptr_w'(req_credits - 1)) ? '0 : p + 1'b1;  // wrap at queue depth
  endfunction

  assign q_empty  = (q_count == '0);
  assign q_full   = (q_count == cnt_w'(req_credits));
  assign tx_last  = tx_busy && (bits_left == '0);
  assign tx_start = !q_empty && (!tx_busy || tx_last);  // back to back after the last bit

  assign head_is_reset = (q_kind[rd_ptr] == req_chain_reset);

  always_comb begin
    head_image = '0;
    if (head_is_reset) begin
      head_image = '1;  // ones for reset_len plus one packet length
    end else begin
      // least significant field leaves first
      head_image[pkt_len-1:0] = {frame_payload(q_data[rd_ptr]),
                                 {frame_bit_size{1'b0}}, q_node[rd_ptr],
                                 {frame_bit_size{1'b0}}, len_field,
                                 {frame_bit_size{1'b0}}, valid_pattern};
    end
  end

  always_ff @(posedge clk) begin
    if (req_valid) begin
      q_kind[wr_ptr] <= req_kind;
      q_node[wr_ptr] <= req_node;
      q_data[wr_ptr] <= req_data;
    end
  end

  always_ff @(posedge clk) begin
    if (cfg_reset) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      q_count    <= '0;
      tx_busy    <= 1'b0;
      bits_left  <= '0;
      tx_sreg    <= '0;
      req_credit <= 1'b0;
    end else begin
      req_credit <= tx_start;  // credit goes back as the entry leaves
      if (req_valid) wr_ptr <= ptr_inc(wr_ptr);
      if (tx_start) rd_ptr <= ptr_inc(rd_ptr);
      q_count <= q_count + cnt_w'(req_valid) - cnt_w'(tx_start);

      if (tx_start) begin
        tx_busy   <= 1'b1;
        tx_sreg   <= head_image;
        bits_left <= head_is_reset ? len_cnt_w'(tx_len - 1) : len_cnt_w'(pkt_len - 1);
      end else begin
        tx_sreg <= tx_sreg >> 1;  // zeros fill behind, line idles low
        if (tx_last) begin
          tx_busy <= 1'b0;
        end else if (tx_busy) begin
          bits_left <= bits_left - 1'b1;
        end
      end
    end
  end

  assign cfg_bit = tx_sreg[0];

  // upstream must hold a credit for every request
  a_queue_no_overflow: assert property (@(posedge clk) disable iff (cfg_reset)
    req_valid |-> !q_full)
    else $error("request queue written while full");

  // image is exactly consumed when the burst ends
  a_idle_line_low: assert property (@(posedge clk) disable iff (cfg_reset)
    !tx_busy |-> !cfg_bit)
    else $error("cfg_bit high while the serializer is idle");

endmodule

// ==== source/config_node.sv ====
`timescale 1ns/1ps

module config_node #(
  parameter int                   node_id       = 0,
  parameter int                   data_bits     = 12,
  parameter logic [data_bits-1:0] default_value = '0
) (
  input  logic                 clk,
  input  logic                 cfg_reset,
  input  logic                 cfg_bit,      // from serializer or previous node
  output logic                 cfg_bit_out,  // oldest shift bit to the next node
  output logic [data_bits-1:0] data_o        // configuration register
);
  import cfg_net_pkg::*;

  localparam int rx_len      = data_bits + data_bits / frame_len + frame_bit_size;
  localparam int pkt_len     = rx_len + 3 * frame_bit_size + id_width + len_width + valid_bit_size;
  localparam int shift_width = pkt_len;  // one whole packet fits
  localparam int num_frames  = rx_len - data_bits;  // framing bits inside the payload
  localparam int frame_step  = frame_len + frame_bit_size;
  localparam logic [len_width-1:0] len_field = len_width'(pkt_len);
  localparam logic [len_width-1:0] skip_len  = len_width'(pkt_len - valid_bit_size);

  // packet layout, msb first
  typedef struct packed {
    logic [rx_len-1:0]         rx;      // framed payload
    logic [frame_bit_size-1:0] f2;
    logic [id_width-1:0]       id;
    logic [frame_bit_size-1:0] f1;
    logic [len_width-1:0]      len;
    logic [frame_bit_size-1:0] f0;
    logic [valid_bit_size-1:0] marker;  // start marker in the lowest bits
  } node_pkt_s;

  // same bits seen as fields or as a plain run for the ones detector
  typedef union packed {
    node_pkt_s              pkt;
    logic [shift_width-1:0] raw;
  } node_shift_u;

  node_shift_u           shift_r;
  logic [len_width-1:0]  bypass_cnt;  // nonzero while a packet interior passes
  logic                  chain_reset;
  logic                  marker_seen, len_ok, pkt_valid, id_match, write_en;
  logic [data_bits-1:0]  payload;     // rx with framing removed
  logic [num_frames-1:0] rx_frames;   // framing bits taken out of rx

  assign chain_reset = &shift_r.raw[reset_len-1:0];           // run of ones
  assign marker_seen = (shift_r.pkt.marker == valid_pattern);
  assign len_ok      = (shift_r.pkt.len == len_field);         // rejects the front of a ones run
  assign pkt_valid   = (bypass_cnt == '0) && marker_seen && len_ok;
  assign id_match    = (shift_r.pkt.id == id_width'(node_id));
  assign write_en    = pkt_valid && id_match;

  // drop a framing bit after every frame_len payload bits
  for (genvar i = 0; i < rx_len - 1; i++) begin : g_deframe
    if ((i + 1) % frame_step != 0) begin : g_data
      assign payload[i - i / frame_step] = shift_r.pkt.rx[i];
    end else begin : g_frame
      assign rx_frames[i / frame_step] = shift_r.pkt.rx[i];
    end
  end
  assign rx_frames[num_frames-1] = shift_r.pkt.rx[rx_len-1];  // msb framing bit

  always_ff @(posedge clk) begin
    if (cfg_reset) begin
      shift_r    <= '0;
      bypass_cnt <= '0;
      data_o     <= default_value;
    end else begin
      shift_r.raw <= {cfg_bit, shift_r.raw[shift_width-1:1]};  // new bit enters at the top
      if (chain_reset) begin
        bypass_cnt <= '0;
        data_o     <= default_value;
      end else if (pkt_valid) begin
        bypass_cnt <= skip_len;  // every node skips the body, addressed or not
        if (id_match) data_o <= payload;
      end else if (bypass_cnt != '0) begin
        bypass_cnt <= bypass_cnt - 1'b1;
      end
    end
  end

  assign cfg_bit_out = shift_r.raw[0];

  // the serializer inserts zero framing everywhere
  a_frames_zero: assert property (@(posedge clk) disable iff (cfg_reset)
    write_en |-> (shift_r.pkt.f0 == '0) && (shift_r.pkt.f1 == '0) &&
                 (shift_r.pkt.f2 == '0) && (rx_frames == '0))
    else $error("node %0d matched a packet with nonzero framing bits", node_id);

endmodule

// ==== source/cfg_change_reporter.sv ====
`timescale 1ns/1ps

module cfg_change_reporter #(
  parameter int num_nodes   = 4,
  parameter int data_bits   = 12,
  parameter int evt_credits = 2
) (
  input  logic                             clk,
  input  logic                             cfg_reset,
  input  logic [num_nodes*data_bits-1:0]   node_data,   // all node registers, node 0 lowest
  input  logic                             evt_credit,  // one credit back per pulse
  output logic                             evt_valid,
  output logic [cfg_net_pkg::id_width-1:0] evt_node,
  output logic [data_bits-1:0]             evt_data
);
  import cfg_net_pkg::*;

  localparam int cred_w = $clog2(evt_credits + 1);

  logic [num_nodes*data_bits-1:0] prev_data;   // node values one cycle ago
  logic [num_nodes-1:0]           changed;     // differs from last cycle
  logic [num_nodes-1:0]           pending;     // changed but not yet reported
  logic [num_nodes-1:0]           grant;       // one hot, node reported this cycle
  logic [cred_w-1:0]              credit_cnt;
  logic [id_width-1:0]            sel_idx;     // lowest pending node
  logic                           sel_any;
  logic                           take;        // an event goes out next cycle

  always_comb begin
    for (int i = 0; i < num_nodes; i++) begin
      changed[i] = (node_data[i*data_bits +: data_bits] != prev_data[i*data_bits +: data_bits]);
    end
  end

  // scan from the top so the lowest index wins
  always_comb begin
    sel_idx = '0;
    sel_any = 1'b0;
    for (int i = num_nodes - 1; i >= 0; i--) begin
      if (pending[i]) begin
        sel_idx = id_width'(i);
        sel_any = 1'b1;
      end
    end
  end

  assign take  = sel_any && (credit_cnt != '0);  // back-pressure holds pending bits
  assign grant = num_nodes'(take) << sel_idx;

  always_ff @(posedge clk) begin
    prev_data <= node_data;
  end

  always_ff @(posedge clk) begin
    if (cfg_reset) begin
      pending    <= '0;
      credit_cnt <= cred_w'(evt_credits);
      evt_valid  <= 1'b0;
    end else begin
      // a change in the grant cycle is covered by the sampled value
      pending    <= (pending | changed) & ~grant;
      credit_cnt <= credit_cnt + cred_w'(evt_credit) - cred_w'(take);
      evt_valid  <= take;
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      evt_node <= sel_idx;
      evt_data <= node_data[sel_idx*data_bits +: data_bits];  // current value
    end
  end

  // consumer returns only credits it was given
  a_credit_bound: assert property (@(posedge clk) disable iff (cfg_reset)
    credit_cnt <= cred_w'(evt_credits))
    else $error("event credit count above its initial value");

endmodule

// ==== source/cfg_net_top.sv ====
`timescale 1ns/1ps

module cfg_net_top #(
  parameter int                             num_nodes     = 4,
  parameter int                             data_bits     = 12,
  parameter logic [num_nodes*data_bits-1:0] node_defaults = {12'h5a5, 12'h0f0, 12'h3c3, 12'h81e},
  parameter int                             req_credits   = 4,
  parameter int                             evt_credits   = 2
) (
  input  logic                             clk,
  input  logic                             cfg_reset,
  // word request port
  input  logic                             req_valid,
  input  cfg_net_pkg::req_kind_e           req_kind,
  input  logic [cfg_net_pkg::id_width-1:0] req_node,
  input  logic [data_bits-1:0]             req_data,
  output logic                             req_credit,
  // change event port
  output logic                             evt_valid,
  output logic [cfg_net_pkg::id_width-1:0] evt_node,
  output logic [data_bits-1:0]             evt_data,
  input  logic                             evt_credit,
  output logic [num_nodes*data_bits-1:0]   node_data   // node registers, node 0 lowest
);

  logic [num_nodes:0] cfg_chain;  // serial line, one tap per node boundary

  cfg_packet_serializer #(
    .data_bits   (data_bits),
    .req_credits (req_credits)
  ) u_serializer (
    .clk        (clk),
    .cfg_reset  (cfg_reset),
    .req_valid  (req_valid),
    .req_kind   (req_kind),
    .req_node   (req_node),
    .req_data   (req_data),
    .req_credit (req_credit),
    .cfg_bit    (cfg_chain[0])
  );

  // node id follows chain position
  for (genvar n = 0; n < num_nodes; n++) begin : g_node
    config_node #(
      .node_id       (n),
      .data_bits     (data_bits),
      .default_value (node_defaults[n*data_bits +: data_bits])
    ) u_node (
      .clk         (clk),
      .cfg_reset   (cfg_reset),
      .cfg_bit     (cfg_chain[n]),
      .cfg_bit_out (cfg_chain[n+1]),  // last tap is the chain end
      .data_o      (node_data[n*data_bits +: data_bits])
    );
  end

  cfg_change_reporter #(
    .num_nodes   (num_nodes),
    .data_bits   (data_bits),
    .evt_credits (evt_credits)
  ) u_reporter (
    .clk        (clk),
    .cfg_reset  (cfg_reset),
    .node_data  (node_data),
    .evt_credit (evt_credit),
    .evt_valid  (evt_valid),
    .evt_node   (evt_node),
    .evt_data   (evt_data)
  );

endmodule

// ==== verification/cfg_net_tb.sv ====
`timescale 1ns/1ps

module cfg_net_tb;
  import cfg_net_pkg::*;

  localparam int num_nodes   = 4;
  localparam int data_bits   = 12;
  localparam int req_credits = 4;
  localparam int evt_credits = 2;
  localparam logic [num_nodes*data_bits-1:0] node_defaults =
    {12'h5a5, 12'h0f0, 12'h3c3, 12'h81e};  // node 0 in the lowest slice
  localparam int wait_limit  = 2000;  // cycles allowed for any single wait

  logic                           clk, cfg_reset;
  logic                           req_valid, req_credit, evt_valid, evt_credit;
  req_kind_e                      req_kind;
  logic [id_width-1:0]            req_node, evt_node;
  logic [data_bits-1:0]           req_data, evt_data;
  logic [num_nodes*data_bits-1:0] node_data;

  logic [19:0]          patterns [64];         // op, node, data per command
  logic [data_bits-1:0] model [num_nodes];     // reference node values
  logic [data_bits-1:0] exp_val [num_nodes][8];  // changes not yet reported, oldest first
  int                   exp_cnt [num_nodes];
  int                   req_cred;   // credits held on the upstream side
  int                   evt_owed;   // events received but not credited back
  bit                   hold_evt;   // withhold event credits

  cfg_net_top #(
    .num_nodes     (num_nodes),
    .data_bits     (data_bits),
    .node_defaults (node_defaults),
    .req_credits   (req_credits),
    .evt_credits   (evt_credits)
  ) DUT (
    .clk        (clk),
    .cfg_reset  (cfg_reset),
    .req_valid  (req_valid),
    .req_kind   (req_kind),
    .req_node   (req_node),
    .req_data   (req_data),
    .req_credit (req_credit),
    .evt_valid  (evt_valid),
    .evt_node   (evt_node),
    .evt_data   (evt_data),
    .evt_credit (evt_credit),
    .node_data  (node_data)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;  // 8 ns period
  end

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x ^= x << 13;
    x ^= x >> 17;
    x ^= x << 5;
    return x;
  endfunction

  task automatic report_failure(input string what);
    $display("%s", what);
    $display("** FAIL **");
    $fatal(1);
  endtask

  // a real change of a node queues one more value to be reported
  task automatic record_change(input int n, input logic [data_bits-1:0] v);
    if (v != model[n]) begin
      assert (exp_cnt[n] < 8) else report_failure("too many unreported changes on one node");
      exp_val[n][exp_cnt[n]] = v;
      exp_cnt[n]++;
    end
    model[n] = v;
  endtask

  task automatic send_request(input req_kind_e kind, input logic [id_width-1:0] node,
                              input logic [data_bits-1:0] data);
    int waited;
    waited = 0;
    while (req_cred == 0) begin  // no credit, no request
      @(negedge clk);
      waited++;
      assert (waited < wait_limit) else report_failure("no request credit came back");
    end
    req_valid = 1'b1;
    req_kind  = kind;
    req_node  = node;
    req_data  = data;
    req_cred--;
    @(negedge clk);
    req_valid = 1'b0;  // a following call raises it again in the same step
  endtask

  task automatic wait_node_value(input int n);
    int waited;
    waited = 0;
    while (node_data[n*data_bits +: data_bits] != model[n] && waited < wait_limit) begin
      @(negedge clk);
      waited++;
    end
    assert (node_data[n*data_bits +: data_bits] == model[n])
      else report_failure($sformatf("error node_data[%0d] = %h, expected %h", n,
                                    node_data[n*data_bits +: data_bits], model[n]));
  endtask

  task automatic wait_events_drained();
    int waited, left;
    waited = 0;
    left   = 1;
    while (left != 0 && waited < wait_limit) begin
      @(negedge clk);
      waited++;
      left = 0;
      for (int i = 0; i < num_nodes; i++) left += exp_cnt[i];
    end
    assert (left == 0) else report_failure("expected change events never arrived");
  endtask

  // outputs are sampled at the rising edge, before the DUT updates them
  always @(posedge clk) begin : event_check
    int hit;
    if (!cfg_reset && req_credit) begin
      req_cred++;
      assert (req_cred <= req_credits) else report_failure("more request credits than sent");
    end
    if (!cfg_reset && evt_valid) begin
      evt_owed++;
      assert (evt_owed <= evt_credits) else report_failure("event issued without a credit");
      assert (evt_node < num_nodes)
        else report_failure($sformatf("error evt_node = %h, no such node", evt_node));
      hit = -1;
      for (int i = exp_cnt[evt_node] - 1; i >= 0; i--) begin
        if (exp_val[evt_node][i] == evt_data) hit = i;  // oldest match wins
      end
      assert (hit >= 0)
        else report_failure($sformatf("error evt_data = %h for evt_node = %h, not a pending change",
                                      evt_data, evt_node));
      // older values were folded into this event
      for (int i = hit + 1; i < exp_cnt[evt_node]; i++) begin
        exp_val[evt_node][i-hit-1] = exp_val[evt_node][i];
      end
      exp_cnt[evt_node] -= hit + 1;
    end
  end

  initial begin : credit_return
    int          delay;
    logic [31:0] cred_rng;
    delay      = 0;
    cred_rng   = xorshift(32'ha094);  // one step ahead of the gap sequence
    evt_credit = 1'b0;
    forever begin
      @(negedge clk);
      evt_credit = 1'b0;
      if (evt_owed > 0 && !hold_evt) begin
        if (delay == 0) begin
          evt_credit = 1'b1;
          evt_owed--;
          cred_rng = xorshift(cred_rng);
          delay    = cred_rng % 5;  // random wait before the next return
        end else begin
          delay--;
        end
      end
    end
  end

  initial begin : stimulus
    logic [3:0]           op;
    logic [id_width-1:0]  node;
    logic [data_bits-1:0] data;
    logic [31:0]          gap_rng;
    bit                   random_gaps;
    int                   pc;
    cfg_reset   = 1'b1;
    req_valid   = 1'b0;
    req_kind    = req_write;
    req_node    = '0;
    req_data    = '0;
    hold_evt    = 1'b0;
    req_cred    = req_credits;
    evt_owed    = 0;
    gap_rng     = 32'ha094;
    random_gaps = 1'b0;
    for (int i = 0; i < num_nodes; i++) begin
      model[i]   = node_defaults[i*data_bits +: data_bits];
      exp_cnt[i] = 0;
    end
    $readmemh("verification/cfg_net_patterns.txt", patterns);
    repeat (8) @(negedge clk);
    cfg_reset = 1'b0;
    assert (node_data == node_defaults)
      else report_failure($sformatf("error node_data = %h, expected %h", node_data, node_defaults));

    pc = 0;
    op = patterns[0][19:16];
    while (op !== 4'h0) begin  // unread entries fall into the default branch
      node = patterns[pc][15:12];
      data = patterns[pc][11:0];
      case (op)
        4'h1: begin
          if (random_gaps) begin
            gap_rng = xorshift(gap_rng);
            repeat (gap_rng % 4) @(negedge clk);
          end
          record_change(node, data);
          send_request(req_write, node, data);
        end
        4'h2: begin
          for (int i = 0; i < num_nodes; i++) begin
            record_change(i, node_defaults[i*data_bits +: data_bits]);
          end
          send_request(req_chain_reset, '0, '0);
        end
        4'h3: begin
          assert (data == model[node])
            else report_failure($sformatf("error model[%0d] = %h, pattern expects %h",
                                          node, model[node], data));
          wait_node_value(node);
        end
        4'h4: hold_evt = 1'b1;
        4'h5: hold_evt = 1'b0;
        4'h6: wait_events_drained();
        4'h7: random_gaps = data[0];
        default: report_failure("unknown command in the pattern file");
      endcase
      pc++;
      op = patterns[pc][19:16];
    end

    wait_events_drained();
    pc = 0;
    while (req_cred != req_credits && pc < wait_limit) begin  // queue empties, credits return
      @(negedge clk);
      pc++;
    end
    if (req_cred == req_credits) begin
      $display("** PASS **");
      $finish;
    end else begin
      report_failure("request credits did not all come back");
    end
  end

endmodule

// ==== verification/cfg_net_patterns.txt ====
// one command per word: op (1 digit), node (1 digit), data (3 digits)
// op 1 write, 2 chain reset, 3 expect, 4 hold and 5 release event credits,
// op 6 wait until every change is reported, 7 request gaps (data 1 random), 0 end
70001
13abc  // last node first, its packet crosses the whole chain
33abc
12123
32123
11456
31456
10789
30789
60000
70000  // back to back, up to the request credits
10111
11222
120f0  // node 2 back to its default
13444
33444
60000
20000  // chain reset, node 2 already at default
3081e
313c3
320f0
335a5
60000
40000  // event credits withheld
10aaa
11bbb
12ccc
10ddd  // node 0 again while still pending
30ddd
50000
60000
11bbb  // same value, no event
13f0f
33f0f
60000
00000

// ==== cfg_net.f ====
source/cfg_net_pkg.sv
source/cfg_packet_serializer.sv
source/config_node.sv
source/cfg_change_reporter.sv
source/cfg_net_top.sv
verification/cfg_net_tb.sv

// ==== Bender.yml ====
package:
  name: cfg_net

sources:
  - source/cfg_net_pkg.sv
  - source/cfg_packet_serializer.sv
  - source/config_node.sv
  - source/cfg_change_reporter.sv
  - source/cfg_net_top.sv
  - target: test
    files:
      - verification/cfg_net_tb.sv
